/* hw/ppu_pkg.sv */
package ppu_pkg;

    // 640x480 visible, 800x525 total
    localparam int h_visible = 640;
    localparam int h_front   = 16;
    localparam int h_sync    = 96;
    localparam int h_total   = 800;

    localparam int v_visible = 480;
    localparam int v_front   = 10;
    localparam int v_sync    = 2;
    localparam int v_total   = 525;

    // outer bound of both boards, frame included
    localparam int board_x  = 234;
    localparam int board_w  = 173;
    localparam int board1_y = 67;
    localparam int board_h  = 173;
    localparam int board2_y = 240;

    // 10x10 grid inside each frame
    localparam int border_w    = 6;
    localparam int square_size = 16;
    localparam int grid_span   = 10 * square_size;
    localparam int col0        = board_x + border_w;
    localparam int row0_b0     = board1_y + border_w;
    localparam int row0_b1     = board2_y + border_w;

    typedef enum logic [1:0] {
        sq_empty = 2'd0,
        sq_miss  = 2'd1,
        sq_hit   = 2'd2,
        sq_ship  = 2'd3
    } square_state_e;

    typedef enum logic [1:0] {
        ship2 = 2'd0,
        ship3 = 2'd1,
        ship4 = 2'd2,
        ship5 = 2'd3
    } ship_type_e;

    // colours are rrrgggbb
    localparam logic [7:0] col_white   = 8'hff;
    localparam logic [7:0] col_frame   = 8'h92;
    localparam logic [7:0] col_grid    = 8'h49;
    localparam logic [7:0] col_water   = 8'h0b;
    localparam logic [7:0] col_miss_b0 = 8'hff;
    localparam logic [7:0] col_miss_b1 = 8'hfc;
    localparam logic [7:0] col_hit     = 8'he0;
    localparam logic [7:0] col_black   = 8'h00;
    localparam logic [7:0] col_ship2   = 8'h6d;
    localparam logic [7:0] col_ship3   = 8'hb6;
    localparam logic [7:0] col_ship4   = 8'h94;
    localparam logic [7:0] col_ship5   = 8'hd1;

endpackage

/* hw/vga_timing.sv */
`timescale 1ns/100ps
module vga_timing (
    input  logic       vga_clk,
    input  logic       rst_n,
    output logic [9:0] next_x,
    output logic [9:0] next_y,
    output logic       hs,
    output logic       vs,
    output logic       blank_n
);
    import ppu_pkg::*;

    logic [9:0] h_count;
    logic [9:0] v_count;
    logic [9:0] h_nxt;
    logic [9:0] v_nxt;
    logic       hs_nxt;
    logic       vs_nxt;
    logic       blank_nxt;
    // bit 0 lines up with the counters, bit 2 with the shader output
    logic [2:0] hs_pipe;
    logic [2:0] vs_pipe;
    logic [2:0] blank_pipe;

    always_comb begin
        h_nxt = h_count + 10'd1;
        v_nxt = v_count;
        if (h_count == 10'(h_total - 1)) begin
            h_nxt = '0;
            if (v_count == 10'(v_total - 1)) begin
                v_nxt = '0;
            end else begin
                v_nxt = v_count + 10'd1;
            end
        end
    end

    // decode the position the counters move to, so stage 0 matches them
    assign hs_nxt = !(h_nxt >= 10'(h_visible + h_front) &&
                      h_nxt < 10'(h_visible + h_front + h_sync));
    assign vs_nxt = !(v_nxt >= 10'(v_visible + v_front) &&
                      v_nxt < 10'(v_visible + v_front + v_sync));
    assign blank_nxt = (h_nxt < 10'(h_visible)) && (v_nxt < 10'(v_visible));

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            h_count    <= '0;
            v_count    <= '0;
            hs_pipe    <= '1;
            vs_pipe    <= '1;
            // stage 0 describes (0,0), which is visible
            blank_pipe <= 3'b001;
        end else begin
            h_count    <= h_nxt;
            v_count    <= v_nxt;
            hs_pipe    <= {hs_pipe[1:0], hs_nxt};
            vs_pipe    <= {vs_pipe[1:0], vs_nxt};
            blank_pipe <= {blank_pipe[1:0], blank_nxt};
        end
    end

    assign next_x  = h_count;
    assign next_y  = v_count;
    assign hs      = hs_pipe[2];
    assign vs      = vs_pipe[2];
    assign blank_n = blank_pipe[2];

    a_counter_range: assert property (@(posedge vga_clk) disable iff (!rst_n)
        (h_count < 10'(h_total)) && (v_count < 10'(v_total)));

endmodule

/* hw/square_table.sv */
`timescale 1ns/100ps
module square_table (
    input  logic                   vga_clk,
    input  logic                   rst_n,
    input  logic                   write_en,
    input  logic                   board,
    input  logic [6:0]             square_index,
    input  ppu_pkg::square_state_e square_state,
    input  ppu_pkg::ship_type_e    ship_type,
    input  logic [2:0]             ship_section,
    input  logic                   vert,
    input  logic                   square_sel,
    input  logic                   rd_board,
    input  logic [6:0]             rd_index,
    output ppu_pkg::square_state_e rd_state,
    output ppu_pkg::ship_type_e    rd_type,
    output logic [2:0]             rd_section,
    output logic                   rd_vert,
    output logic                   rd_sel
);
    import ppu_pkg::*;

    // entry is {state, type, section, vert, sel}
    logic [8:0] squares [0:1][0:99];
    logic [8:0] rd_entry;

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            squares <= '{default: '0};
        end else if (write_en) begin
            squares[board][square_index] <= {square_state, ship_type, ship_section,
                                             vert, square_sel};
        end
    end

    // indexes past 99 read as an empty square
    always_comb begin
        if (rd_index < 7'd100) begin
            rd_entry = squares[rd_board][rd_index];
        end else begin
            rd_entry = '0;
        end
    end

    assign rd_state   = square_state_e'(rd_entry[8:7]);
    assign rd_type    = ship_type_e'(rd_entry[6:5]);
    assign rd_section = rd_entry[4:2];
    assign rd_vert    = rd_entry[1];
    assign rd_sel     = rd_entry[0];

    a_write_index: assert property (@(posedge vga_clk) disable iff (!rst_n)
        write_en |-> (square_index < 7'd100));

endmodule

/* hw/grid_locator.sv */
`timescale 1ns/100ps
module grid_locator (
    input  logic       vga_clk,
    input  logic       rst_n,
    input  logic [9:0] next_x,
    input  logic [9:0] next_y,
    output logic       vis,
    output logic       in_game,
    output logic       in_grid,
    output logic       board_sel,
    output logic [6:0] square_index,
    output logic [3:0] off_x,
    output logic [3:0] off_y
);
    import ppu_pkg::*;

    logic       vis_c;
    logic       game_c;
    logic       col_c;
    logic       b0_c;
    logic       b1_c;
    logic [9:0] dx;
    logic [9:0] dy;
    logic [6:0] index_c;

    assign vis_c = (next_x < 10'(h_visible)) && (next_y < 10'(v_visible));

    // both boards and their frames as one rectangle
    assign game_c = (next_x >= 10'(board_x)) && (next_x < 10'(board_x + board_w)) &&
                    (next_y >= 10'(board1_y)) && (next_y < 10'(board2_y + board_h));

    assign col_c = (next_x >= 10'(col0)) && (next_x < 10'(col0 + grid_span));
    assign b0_c  = col_c && (next_y >= 10'(row0_b0)) && (next_y < 10'(row0_b0 + grid_span));
    assign b1_c  = col_c && (next_y >= 10'(row0_b1)) && (next_y < 10'(row0_b1 + grid_span));

    assign dx = next_x - 10'(col0);
    assign dy = b1_c ? (next_y - 10'(row0_b1)) : (next_y - 10'(row0_b0));

    // row * 10 + column, upper nibble of each offset picks the square
    always_comb begin
        if (b0_c || b1_c) begin
            index_c = {3'b000, dy[7:4]} * 7'd10 + {3'b000, dx[7:4]};
        end else begin
            index_c = '0;
        end
    end

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            vis          <= 1'b0;
            in_game      <= 1'b0;
            in_grid      <= 1'b0;
            board_sel    <= 1'b0;
            square_index <= '0;
            off_x        <= '0;
            off_y        <= '0;
        end else begin
            vis          <= vis_c;
            in_game      <= game_c;
            in_grid      <= b0_c || b1_c;
            board_sel    <= b1_c;
            square_index <= index_c;
            off_x        <= dx[3:0];
            off_y        <= dy[3:0];
        end
    end

    a_grid_index: assert property (@(posedge vga_clk) disable iff (!rst_n)
        in_grid |-> (square_index < 7'd100) && in_game);

endmodule

/* hw/sprite_shader.sv */
`timescale 1ns/100ps
module sprite_shader (
    input  logic                   vga_clk,
    input  logic                   rst_n,
    input  logic                   vis,
    input  logic                   in_game,
    input  logic                   in_grid,
    input  logic                   board_sel,
    input  logic [3:0]             off_x,
    input  logic [3:0]             off_y,
    input  ppu_pkg::square_state_e sq_state,
    input  ppu_pkg::ship_type_e    sq_type,
    input  logic [2:0]             sq_section,
    input  logic                   sq_vert,
    input  logic                   sq_sel,
    output logic [7:0]             r,
    output logic [7:0]             g,
    output logic [7:0]             b
);
    import ppu_pkg::*;

    logic       on_line;
    logic [3:0] len_off;
    logic [7:0] ship_col;
    logic [7:0] obj_col;
    logic [7:0] pix_c;
    logic [7:0] pix_q;

    function automatic logic in_window(input logic [3:0] v, input logic [3:0] lo,
                                       input logic [3:0] hi);
        return (v >= lo) && (v <= hi);
    endfunction

    assign on_line = (off_x == 4'd0) || (off_y == 4'd0);
    // offset along the ship's length
    assign len_off = sq_vert ? off_y : off_x;

    always_comb begin
        case (sq_type)
            ship2:   ship_col = col_ship2;
            ship3:   ship_col = col_ship3;
            ship4:   ship_col = col_ship4;
            default: ship_col = col_ship5;
        endcase
    end

    always_comb begin
        case (sq_state)
            sq_miss: begin
                if (in_window(off_x, 4'd6, 4'd9) && in_window(off_y, 4'd6, 4'd9)) begin
                    obj_col = board_sel ? col_miss_b1 : col_miss_b0;
                end else begin
                    obj_col = col_water;
                end
            end
            sq_hit: begin
                if (in_window(off_x, 4'd4, 4'd11) && in_window(off_y, 4'd4, 4'd11)) begin
                    obj_col = col_hit;
                end else begin
                    obj_col = col_water;
                end
            end
            // bow of the ship is dark
            sq_ship: obj_col = (sq_section == 3'd0 && len_off < 4'd4) ? col_black : ship_col;
            default: obj_col = col_water;
        endcase
    end

    always_comb begin
        if (!vis) begin
            pix_c = '0;
        end else if (!in_game) begin
            pix_c = col_white;
        end else if (!in_grid) begin
            pix_c = col_frame;
        end else if (on_line) begin
            pix_c = col_grid;
        end else begin
            pix_c = sq_sel ? ~obj_col : obj_col;
        end
    end

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_q <= '0;
        end else begin
            pix_q <= pix_c;
        end
    end

    assign r = {pix_q[7:5], 5'b0};
    assign g = {pix_q[4:2], 5'b0};
    assign b = {pix_q[1:0], 6'b0};

endmodule

/* hw/ppu.sv */
`timescale 1ns/100ps
module ppu (
    input  logic                   vga_clk,
    input  logic                   rst_n,
    input  logic                   write_en,
    input  logic                   board,
    input  logic [6:0]             square_index,
    input  ppu_pkg::square_state_e square_state,
    input  ppu_pkg::ship_type_e    ship_type,
    input  logic [2:0]             ship_section,
    input  logic                   vert,
    input  logic                   square_sel,
    output logic [7:0]             r,
    output logic [7:0]             g,
    output logic [7:0]             b,
    output logic                   hs,
    output logic                   vs,
    output logic                   blank_n
);
    import ppu_pkg::*;

    logic [9:0]    next_x;
    logic [9:0]    next_y;
    // locator outputs, one cycle behind the counters
    logic          vis;
    logic          in_game;
    logic          in_grid;
    logic          board_sel;
    logic [6:0]    loc_index;
    logic [3:0]    off_x;
    logic [3:0]    off_y;
    // stored square under the current pixel
    square_state_e sq_state;
    ship_type_e    sq_type;
    logic [2:0]    sq_section;
    logic          sq_vert;
    logic          sq_sel;

    vga_timing u_timing (
        .vga_clk (vga_clk),
        .rst_n   (rst_n),
        .next_x  (next_x),
        .next_y  (next_y),
        .hs      (hs),
        .vs      (vs),
        .blank_n (blank_n)
    );

    square_table u_table (
        .vga_clk      (vga_clk),
        .rst_n        (rst_n),
        .write_en     (write_en),
        .board        (board),
        .square_index (square_index),
        .square_state (square_state),
        .ship_type    (ship_type),
        .ship_section (ship_section),
        .vert         (vert),
        .square_sel   (square_sel),
        .rd_board     (board_sel),
        .rd_index     (loc_index),
        .rd_state     (sq_state),
        .rd_type      (sq_type),
        .rd_section   (sq_section),
        .rd_vert      (sq_vert),
        .rd_sel       (sq_sel)
    );

    grid_locator u_locator (
        .vga_clk      (vga_clk),
        .rst_n        (rst_n),
        .next_x       (next_x),
        .next_y       (next_y),
        .vis          (vis),
        .in_game      (in_game),
        .in_grid      (in_grid),
        .board_sel    (board_sel),
        .square_index (loc_index),
        .off_x        (off_x),
        .off_y        (off_y)
    );

    sprite_shader u_shader (
        .vga_clk    (vga_clk),
        .rst_n      (rst_n),
        .vis        (vis),
        .in_game    (in_game),
        .in_grid    (in_grid),
        .board_sel  (board_sel),
        .off_x      (off_x),
        .off_y      (off_y),
        .sq_state   (sq_state),
        .sq_type    (sq_type),
        .sq_section (sq_section),
        .sq_vert    (sq_vert),
        .sq_sel     (sq_sel),
        .r          (r),
        .g          (g),
        .b          (b)
    );

endmodule

/* tests/tb_ppu.sv */
`timescale 1ns/100ps
module tb_ppu;
    import ppu_pkg::*;

    localparam int max_writes     = 32;
    localparam int max_probes     = 64;
    localparam int frame_cycles   = h_total * v_total;
    localparam int timeout_cycles = frame_cycles + 1000;

    logic          vga_clk;
    logic          rst_n;
    logic          write_en;
    logic          board;
    logic [6:0]    square_index;
    square_state_e square_state;
    ship_type_e    ship_type;
    logic [2:0]    ship_section;
    logic          vert;
    logic          square_sel;
    logic [7:0]    r;
    logic [7:0]    g;
    logic [7:0]    b;
    logic          hs;
    logic          vs;
    logic          blank_n;

    // writes and probes from the input file
    logic          w_board   [max_writes];
    logic [6:0]    w_index   [max_writes];
    logic [1:0]    w_state   [max_writes];
    logic [1:0]    w_type    [max_writes];
    logic [2:0]    w_section [max_writes];
    logic          w_vert    [max_writes];
    logic          w_sel     [max_writes];
    int            p_x       [max_probes];
    int            p_y       [max_probes];
    logic [7:0]    p_col     [max_probes];
    int            num_writes;
    int            num_probes;
    int            next_probe;
    // edges since reset release
    int            edge_count;
    int            wd_count;

    ppu u_dut (
        .vga_clk      (vga_clk),
        .rst_n        (rst_n),
        .write_en     (write_en),
        .board        (board),
        .square_index (square_index),
        .square_state (square_state),
        .ship_type    (ship_type),
        .ship_section (ship_section),
        .vert         (vert),
        .square_sel   (square_sel),
        .r            (r),
        .g            (g),
        .b            (b),
        .hs           (hs),
        .vs           (vs),
        .blank_n      (blank_n)
    );

    initial begin
        vga_clk = 1'b0;
        forever #5 vga_clk = ~vga_clk;
    end

    // rrrgggbb spread over three 8-bit channels
    function automatic logic [23:0] expand_colour(input logic [7:0] c);
        return {c[7:5], 5'b0, c[4:2], 5'b0, c[1:0], 6'b0};
    endfunction

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_on_failure($sformatf("[FAIL] time %0t: %s: got %0h, expected %0h",
                                      $time, what, actual, expected));
        end
    endtask

    task automatic load_input();
        int             fd;
        int             code;
        int             a [7];
        logic [7:0]     colour;
        logic [127:0]   tag;
        logic [1279:0]  rest;
        fd = $fopen("tests/ppu_input.txt", "r");
        if (fd == 0) begin
            stop_on_failure("cannot open tests/ppu_input.txt");
        end
        num_writes = 0;
        num_probes = 0;
        code = $fscanf(fd, "%s", tag);
        while (code == 1) begin
            if (tag == "#") begin
                code = $fgets(rest, fd);
            end else if (tag == "W") begin
                code = $fscanf(fd, "%d %d %d %d %d %d %d",
                               a[0], a[1], a[2], a[3], a[4], a[5], a[6]);
                if (code != 7 || num_writes == max_writes) begin
                    stop_on_failure("bad or too many write lines in input file");
                end
                w_board[num_writes]   = a[0][0];
                w_index[num_writes]   = a[1][6:0];
                w_state[num_writes]   = a[2][1:0];
                w_type[num_writes]    = a[3][1:0];
                w_section[num_writes] = a[4][2:0];
                w_vert[num_writes]    = a[5][0];
                w_sel[num_writes]     = a[6][0];
                num_writes++;
            end else if (tag == "P") begin
                code = $fscanf(fd, "%d %d %h", a[0], a[1], colour);
                if (code != 3 || num_probes == max_probes) begin
                    stop_on_failure("bad or too many probe lines in input file");
                end
                p_x[num_probes]   = a[0];
                p_y[num_probes]   = a[1];
                p_col[num_probes] = colour;
                num_probes++;
            end else begin
                stop_on_failure("unknown line type in input file");
            end
            code = $fscanf(fd, "%s", tag);
        end
        $fclose(fd);
        if (num_writes == 0 || num_probes == 0) begin
            stop_on_failure("input file holds no writes or no probes");
        end
    endtask

    task automatic apply_writes();
        for (int i = 0; i < num_writes; i++) begin
            @(posedge vga_clk);
            #1;
            write_en     = 1'b1;
            board        = w_board[i];
            square_index = w_index[i];
            square_state = square_state_e'(w_state[i]);
            ship_type    = ship_type_e'(w_type[i]);
            ship_section = w_section[i];
            vert         = w_vert[i];
            square_sel   = w_sel[i];
        end
        @(posedge vga_clk);
        #1;
        write_en = 1'b0;
    endtask

    // outputs after edge n belong to raster position n-2
    task automatic check_pixel(input int pos);
        int         x;
        int         y;
        logic       vis_exp;
        logic [2:0] sync_exp;
        x = pos % h_total;
        y = (pos / h_total) % v_total;
        vis_exp = (x < h_visible) && (y < v_visible);
        sync_exp[2] = !((x >= h_visible + h_front) && (x < h_visible + h_front + h_sync));
        sync_exp[1] = !((y >= v_visible + v_front) && (y < v_visible + v_front + v_sync));
        sync_exp[0] = vis_exp;
        check_value({hs, vs, blank_n}, sync_exp, "hs, vs, blank_n");
        if (!vis_exp) begin
            check_value({r, g, b}, 24'h0, "colour during blanking");
        end
        if (next_probe < num_probes && p_x[next_probe] == x && p_y[next_probe] == y) begin
            check_value({r, g, b}, expand_colour(p_col[next_probe]),
                        $sformatf("pixel (%0d,%0d)", x, y));
            next_probe++;
        end
    endtask

    task automatic run_frame();
        while (edge_count < frame_cycles + 1) begin
            @(posedge vga_clk);
            edge_count++;
            @(negedge vga_clk);
            if (edge_count >= 2) begin
                check_pixel(edge_count - 2);
            end
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        write_en     = 1'b0;
        board        = 1'b0;
        square_index = '0;
        square_state = sq_empty;
        ship_type    = ship2;
        ship_section = '0;
        vert         = 1'b0;
        square_sel   = 1'b0;
        edge_count   = 0;
        next_probe   = 0;
        load_input();
        repeat (4) @(posedge vga_clk);
        #1;
        rst_n = 1'b1;
        #1;
        check_value({hs, vs, blank_n}, 3'b110, "sync and blank after reset");
        check_value({r, g, b}, 24'h0, "colour after reset");
        fork
            apply_writes();
            run_frame();
        join
        check_value(next_probe, num_probes, "probes matched in raster order");
        $display("All checks passed");
        $finish;
    end

    // watchdog over the whole run
    initial begin
        wd_count = 0;
        forever begin
            @(posedge vga_clk);
            wd_count++;
            if (wd_count >= timeout_cycles) begin
                stop_on_failure($sformatf("timeout: run still going after %0d cycles",
                                          wd_count));
            end
        end
    end

endmodule

/* tests/ppu_input.txt */
# W board index state type section vert sel  (decimal, state 0..3, type 0..3)
# P x y colour  (decimal position, expected rrrgggbb byte in hex, raster order)
W 0 0 1 0 0 0 0
W 1 11 1 0 0 0 0
W 0 22 2 0 0 0 0
W 0 43 3 1 0 0 0
W 0 44 3 1 1 0 0
W 1 56 3 3 0 1 0
W 1 66 3 3 1 1 0
W 1 33 2 0 0 0 1
P 10 10 ff
P 233 67 ff
P 234 67 92
P 300 70 92
P 240 73 49
P 245 79 0b
P 246 79 ff
P 249 82 ff
P 250 82 0b
P 700 100 00
P 276 108 0b
P 275 109 0b
P 276 109 e0
P 283 116 e0
P 284 116 0b
P 325 125 0b
P 320 130 49
P 295 137 49
P 300 138 b6
P 289 140 00
P 291 140 00
P 292 140 b6
P 305 140 b6
P 300 236 92
P 261 268 0b
P 262 268 fc
P 265 271 fc
P 265 272 0b
P 295 294 49
P 288 298 49
P 291 298 f4
P 292 298 1f
P 406 300 92
P 407 300 ff
P 345 327 00
P 337 329 00
P 337 330 d1
P 340 343 d1
P 300 412 92
P 300 413 ff
P 639 479 ff
P 100 500 00

/* files.f */
hw/ppu_pkg.sv
hw/vga_timing.sv
hw/square_table.sv
hw/grid_locator.sv
hw/sprite_shader.sv
hw/ppu.sv
tests/tb_ppu.sv
